// File: design/pkg_kernel.sv
`default_nettype none

package pkg_kernel;

    // ----------------------------------------------------------
    // Widths
    // ----------------------------------------------------------
    localparam int vertex_id_width = 32;
    localparam int result_width    = 64;
    localparam int flags_width     = 32;

    // Link depth used when the top level sets nothing else
    localparam int credit_depth_default = 4;

    // ----------------------------------------------------------
    // Descriptor and link payload
    // ----------------------------------------------------------
    typedef struct packed {
        logic [vertex_id_width-1:0] base_vertex;
        logic [vertex_id_width-1:0] vertex_count;
        // Bit 0 selects byte order
        logic [flags_width-1:0]     flags;
    } kernel_descriptor;

    // One vertex per beat
    typedef struct packed {
        logic [vertex_id_width-1:0] id;
        logic                       last;
    } vertex_item;

    // ----------------------------------------------------------
    // User-managed handshake states
    // ----------------------------------------------------------
    typedef enum logic [2:0] {
        state_reset,
        state_idle,
        state_setup,
        state_ready,
        state_start,
        state_busy,
        state_done
    } control_state;

endpackage : pkg_kernel

`default_nettype wire

// File: design/credit_link_if.sv
`timescale 1ns/100ps
`default_nettype none

interface credit_link_if #(
    parameter type payload_t = logic
);

    // Beat qualifier, only driven with a credit in hand
    logic     valid;
    payload_t payload;
    // Pulse per receiver slot freed
    logic     credit_return;
    // Sender idle with every credit home
    logic     setup_ready;

    modport sender (
        output valid,
        output payload,
        output setup_ready,
        input  credit_return
    );

    modport receiver (
        input  valid,
        input  payload,
        input  setup_ready,
        output credit_return
    );

endinterface : credit_link_if

`default_nettype wire

// File: design/kernel_control.sv
`timescale 1ns/100ps
`default_nettype none

module kernel_control (
    input  logic                         ap_clk,
    input  logic                         areset_control,
    input  logic                         ap_start,
    input  pkg_kernel::kernel_descriptor descriptor_in,
    input  logic                         cu_setup,
    input  logic                         cu_done,
    output logic                         ap_ready,
    output logic                         ap_done,
    output logic                         ap_idle,
    output pkg_kernel::kernel_descriptor descriptor_out,
    output logic                         descriptor_valid,
    output logic                         endian
);

    import pkg_kernel::*;

    control_state current_state;
    control_state next_state;

    // Input stage
    logic             ap_start_reg;
    logic             cu_setup_reg;
    logic             cu_done_reg;
    kernel_descriptor descriptor_in_reg;

    // Done of the previous job lingers until the pipeline clears it
    logic done_armed;

    // First output stage
    logic ap_ready_reg;
    logic ap_done_reg;
    logic ap_idle_reg;
    logic descriptor_valid_reg;
    logic endian_reg;

    // ----------------------------------------------------------
    // Input registers
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_start_reg <= 1'b0;
            cu_setup_reg <= 1'b0;
            cu_done_reg  <= 1'b0;
        end else begin
            ap_start_reg <= ap_start;
            cu_setup_reg <= cu_setup;
            cu_done_reg  <= cu_done;
        end
    end

    // Second descriptor stage loads only when a job is accepted
    always_ff @(posedge ap_clk) begin
        descriptor_in_reg <= descriptor_in;
        if (ap_start_reg && (current_state == state_setup || current_state == state_done)) begin
            descriptor_out <= descriptor_in_reg;
        end
    end

    // Armed once done is seen low during busy
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            done_armed <= 1'b0;
        end else if (current_state == state_start) begin
            done_armed <= 1'b0;
        end else if (current_state == state_busy && !cu_done_reg) begin
            done_armed <= 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Handshake FSM
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            current_state <= state_reset;
        end else begin
            current_state <= next_state;
        end
    end

    always_comb begin
        next_state = current_state;
        case (current_state)
            state_reset: next_state = state_idle;
            state_idle:  next_state = state_setup;
            // Wait for the host
            state_setup: if (ap_start_reg) next_state = state_ready;
            // Wait for all issue credits to come home
            state_ready: if (cu_setup_reg) next_state = state_start;
            state_start: next_state = state_busy;
            state_busy:  if (cu_done_reg && done_armed) next_state = state_done;
            state_done:  if (ap_start_reg) next_state = state_ready;
            default:     next_state = state_reset;
        endcase
    end

    // ----------------------------------------------------------
    // Status outputs, two register stages
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_ready_reg         <= 1'b0;
            ap_done_reg          <= 1'b0;
            ap_idle_reg          <= 1'b1;
            descriptor_valid_reg <= 1'b0;
            endian_reg           <= 1'b0;
        end else begin
            ap_ready_reg         <= (current_state == state_ready);
            ap_done_reg          <= (current_state == state_done);
            ap_idle_reg          <= (current_state == state_reset) ||
                                    (current_state == state_idle)  ||
                                    (current_state == state_setup) ||
                                    (current_state == state_done);
            // Descriptor published in start and busy
            descriptor_valid_reg <= (current_state == state_start) ||
                                    (current_state == state_busy);
            endian_reg           <= ((current_state == state_start) ||
                                     (current_state == state_busy)) && descriptor_out.flags[0];
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            ap_ready         <= 1'b0;
            ap_done          <= 1'b0;
            ap_idle          <= 1'b1;
            descriptor_valid <= 1'b0;
            endian           <= 1'b0;
        end else begin
            ap_ready         <= ap_ready_reg;
            ap_done          <= ap_done_reg;
            ap_idle          <= ap_idle_reg;
            descriptor_valid <= descriptor_valid_reg;
            endian           <= endian_reg;
        end
    end

endmodule : kernel_control

`default_nettype wire

// File: design/vertex_issue.sv
`timescale 1ns/100ps
`default_nettype none

module vertex_issue #(
    parameter int credit_depth = pkg_kernel::credit_depth_default
) (
    input  logic                         ap_clk,
    input  logic                         areset_control,
    input  pkg_kernel::kernel_descriptor descriptor,
    input  logic                         descriptor_valid,
    output logic                         cu_setup,
    credit_link_if.sender                link
);

    import pkg_kernel::*;

    localparam int count_width = $clog2(credit_depth + 1);

    logic                       descriptor_valid_q;
    logic                       job_load;
    logic                       active;
    logic                       send;
    logic [vertex_id_width-1:0] next_id;
    logic [vertex_id_width-1:0] remaining;
    logic [count_width-1:0]     credits;

    // New job on the rising edge of descriptor_valid
    assign job_load = descriptor_valid && !descriptor_valid_q;
    // One id per cycle, only with a free slot downstream
    assign send = active && (credits != '0);

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            descriptor_valid_q <= 1'b0;
            active             <= 1'b0;
            link.valid         <= 1'b0;
        end else begin
            descriptor_valid_q <= descriptor_valid;
            link.valid         <= send;
            if (job_load) begin
                active <= 1'b1;
            end else if (send && remaining == vertex_id_width'(1)) begin
                active <= 1'b0;
            end
        end
    end

    // Range walk and outgoing beat
    always_ff @(posedge ap_clk) begin
        if (job_load) begin
            next_id   <= descriptor.base_vertex;
            remaining <= descriptor.vertex_count;
        end else if (send) begin
            next_id   <= next_id + 1'b1;
            remaining <= remaining - 1'b1;
        end
        if (send) begin
            link.payload <= vertex_item'{id: next_id, last: (remaining == vertex_id_width'(1))};
        end
    end

    // Credit counter, down per beat and up per return
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            credits <= count_width'(credit_depth);
        end else begin
            credits <= credits - count_width'(send) + count_width'(link.credit_return);
        end
    end

    assign link.setup_ready = (credits == count_width'(credit_depth)) && !active;
    assign cu_setup         = link.setup_ready;

endmodule : vertex_issue

`default_nettype wire

// File: design/vertex_transform.sv
`timescale 1ns/100ps
`default_nettype none

module vertex_transform #(
    parameter int credit_depth = pkg_kernel::credit_depth_default
) (
    input  logic            ap_clk,
    input  logic            areset_control,
    input  logic            endian,
    credit_link_if.receiver link_in,
    credit_link_if.sender   link_out
);

    import pkg_kernel::*;

    localparam int count_width = $clog2(credit_depth + 1);
    localparam int ptr_width   = (credit_depth > 1) ? $clog2(credit_depth) : 1;
    localparam logic [ptr_width-1:0] ptr_last = ptr_width'(credit_depth - 1);

    vertex_item             buffer [credit_depth];
    vertex_item             head;
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] fill;
    logic [count_width-1:0] credits;
    logic                   pop;

    // Reverse byte order of an id
    function automatic logic [vertex_id_width-1:0] byte_swap(
        input logic [vertex_id_width-1:0] value
    );
        logic [vertex_id_width-1:0] swapped;
        for (int i = 0; i < vertex_id_width / 8; i++) begin
            swapped[8*i +: 8] = value[vertex_id_width - 8*(i + 1) +: 8];
        end
        return swapped;
    endfunction

    assign head = buffer[rd_ptr];
    // Forward only with a downstream credit
    assign pop  = (fill != '0) && (credits != '0);

    // ----------------------------------------------------------
    // Receive FIFO
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (link_in.valid) begin
            buffer[wr_ptr] <= link_in.payload;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            fill    <= '0;
            credits <= count_width'(credit_depth);
        end else begin
            if (link_in.valid) wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
            fill    <= fill + count_width'(link_in.valid) - count_width'(pop);
            credits <= credits - count_width'(pop) + count_width'(link_out.credit_return);
        end
    end

    // ----------------------------------------------------------
    // Registered output and credit return
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            link_out.valid        <= 1'b0;
            link_in.credit_return <= 1'b0;
        end else begin
            link_out.valid        <= pop;
            link_in.credit_return <= pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (pop) begin
            link_out.payload <= vertex_item'{id: endian ? byte_swap(head.id) : head.id,
                                             last: head.last};
        end
    end

    assign link_out.setup_ready = (credits == count_width'(credit_depth)) && (fill == '0);

endmodule : vertex_transform

`default_nettype wire

// File: design/result_accumulate.sv
`timescale 1ns/100ps
`default_nettype none

module result_accumulate #(
    parameter int credit_depth = pkg_kernel::credit_depth_default
) (
    input  logic                              ap_clk,
    input  logic                              areset_control,
    input  logic                              descriptor_valid,
    credit_link_if.receiver                   link_in,
    output logic [pkg_kernel::result_width-1:0] result,
    output logic                              cu_done
);

    import pkg_kernel::*;

    localparam int count_width = $clog2(credit_depth + 1);
    localparam int ptr_width   = (credit_depth > 1) ? $clog2(credit_depth) : 1;
    localparam logic [ptr_width-1:0] ptr_last = ptr_width'(credit_depth - 1);

    vertex_item             buffer [credit_depth];
    vertex_item             head;
    logic [ptr_width-1:0]   wr_ptr;
    logic [ptr_width-1:0]   rd_ptr;
    logic [count_width-1:0] fill;
    logic                   pop;
    logic                   descriptor_valid_q;

    assign head = buffer[rd_ptr];
    // Drain one item every cycle
    assign pop  = (fill != '0);

    always_ff @(posedge ap_clk) begin
        if (link_in.valid) begin
            buffer[wr_ptr] <= link_in.payload;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_control) begin
            wr_ptr                <= '0;
            rd_ptr                <= '0;
            fill                  <= '0;
            link_in.credit_return <= 1'b0;
            descriptor_valid_q    <= 1'b0;
            result                <= '0;
            cu_done               <= 1'b0;
        end else begin
            if (link_in.valid) wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
            if (pop) rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
            fill                  <= fill + count_width'(link_in.valid) - count_width'(pop);
            link_in.credit_return <= pop;
            descriptor_valid_q    <= descriptor_valid;
            // Fresh job clears the sum and done
            if (descriptor_valid && !descriptor_valid_q) begin
                result  <= '0;
                cu_done <= 1'b0;
            end else if (pop) begin
                result <= result + result_width'(head.id);
                if (head.last) cu_done <= 1'b1;
            end
        end
    end

endmodule : result_accumulate

`default_nettype wire

// File: design/graph_kernel_top.sv
`timescale 1ns/100ps
`default_nettype none

module graph_kernel_top #(
    parameter int credit_depth = pkg_kernel::credit_depth_default
) (
    input  logic                                   ap_clk,
    input  logic                                   areset_control,
    input  logic                                   ap_start,
    input  logic [pkg_kernel::vertex_id_width-1:0] base_vertex,
    input  logic [pkg_kernel::vertex_id_width-1:0] vertex_count,
    input  logic [pkg_kernel::flags_width-1:0]     flags,
    output logic                                   ap_ready,
    output logic                                   ap_done,
    output logic                                   ap_idle,
    output logic [pkg_kernel::result_width-1:0]    result
);

    import pkg_kernel::*;

    kernel_descriptor descriptor_in;
    kernel_descriptor descriptor;
    logic             descriptor_valid;
    logic             endian;
    logic             cu_setup;
    logic             cu_done;

    // Issue to transform, then transform to accumulate
    credit_link_if #(.payload_t(vertex_item)) link_issue ();
    credit_link_if #(.payload_t(vertex_item)) link_xform ();

    assign descriptor_in = '{base_vertex: base_vertex, vertex_count: vertex_count, flags: flags};

    kernel_control kernel_control_i (
        .ap_clk          (ap_clk),
        .areset_control  (areset_control),
        .ap_start        (ap_start),
        .descriptor_in   (descriptor_in),
        .cu_setup        (cu_setup),
        .cu_done         (cu_done),
        .ap_ready        (ap_ready),
        .ap_done         (ap_done),
        .ap_idle         (ap_idle),
        .descriptor_out  (descriptor),
        .descriptor_valid(descriptor_valid),
        .endian          (endian)
    );

    vertex_issue #(.credit_depth(credit_depth)) vertex_issue_i (
        .ap_clk          (ap_clk),
        .areset_control  (areset_control),
        .descriptor      (descriptor),
        .descriptor_valid(descriptor_valid),
        .cu_setup        (cu_setup),
        .link            (link_issue.sender)
    );

    vertex_transform #(.credit_depth(credit_depth)) vertex_transform_i (
        .ap_clk        (ap_clk),
        .areset_control(areset_control),
        .endian        (endian),
        .link_in       (link_issue.receiver),
        .link_out      (link_xform.sender)
    );

    result_accumulate #(.credit_depth(credit_depth)) result_accumulate_i (
        .ap_clk          (ap_clk),
        .areset_control  (areset_control),
        .descriptor_valid(descriptor_valid),
        .link_in         (link_xform.receiver),
        .result          (result),
        .cu_done         (cu_done)
    );

endmodule : graph_kernel_top

`default_nettype wire

// File: bench/graph_kernel_tb.sv
`timescale 1ns/100ps
`default_nettype none

module graph_kernel_tb;

    import pkg_kernel::*;

    // ----------------------------------------------------------
    // Run shape
    // ----------------------------------------------------------
    localparam int job_total  = 10;
    localparam int link_depth = 4;
    // Bound on any single handshake wait
    localparam int wait_limit = 3000;

    logic                       ap_clk;
    logic                       areset_control;
    logic                       ap_start;
    logic [vertex_id_width-1:0] base_vertex;
    logic [vertex_id_width-1:0] vertex_count;
    logic [flags_width-1:0]     flags;
    logic                       ap_ready;
    logic                       ap_done;
    logic                       ap_idle;
    logic [result_width-1:0]    result;

    // Job table filled before reset is released
    logic [31:0] job_base   [job_total];
    logic [31:0] job_count  [job_total];
    logic        job_endian [job_total];

    logic [31:0] lfsr_state;
    int          watchdog_cycles;

    graph_kernel_top #(.credit_depth(link_depth)) graph_kernel_top_i (
        .ap_clk        (ap_clk),
        .areset_control(areset_control),
        .ap_start      (ap_start),
        .base_vertex   (base_vertex),
        .vertex_count  (vertex_count),
        .flags         (flags),
        .ap_ready      (ap_ready),
        .ap_done       (ap_done),
        .ap_idle       (ap_idle),
        .result        (result)
    );

    // 8 ns clock
    initial begin
        ap_clk = 1'b0;
        forever #4 ap_clk = ~ap_clk;
    end

    task automatic stop_with_error(input string message);
        $display("%s", message);
        $display("TB FAILED");
        $fatal(1);
    endtask

    // ----------------------------------------------------------
    // Stimulus source and reference model
    // ----------------------------------------------------------
    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    // One LFSR step per bit
    task automatic take_random(input int bits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < bits; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    // Sum of ids over the range with 32-bit id wrap
    function automatic logic [63:0] model_sum(input logic [31:0] base, input logic [31:0] count,
                                              input logic endian);
        logic [63:0] sum;
        logic [31:0] id;
        sum = '0;
        for (int unsigned i = 0; i < count; i++) begin
            id = base + i;
            if (endian) begin
                id = {id[7:0], id[15:8], id[23:16], id[31:24]};
            end
            sum = sum + {32'd0, id};
        end
        return sum;
    endfunction

    task automatic plan_jobs();
        logic [31:0] value;
        // Plain sum then swapped sum
        job_base[0]   = 32'h0000_0010;
        job_count[0]  = 32'd5;
        job_endian[0] = 1'b0;
        job_base[1]   = 32'h0102_0304;
        job_count[1]  = 32'd7;
        job_endian[1] = 1'b1;
        // Single vertex job
        job_base[2]   = 32'h00ab_cdef;
        job_count[2]  = 32'd1;
        job_endian[2] = 1'b1;
        // Well past the link depth and across the id wrap
        job_base[3]   = 32'hffff_fff0;
        job_count[3]  = 32'd40;
        job_endian[3] = 1'b0;
        for (int j = 4; j < job_total; j++) begin
            take_random(32, value);
            job_base[j] = value;
            take_random(6, value);
            job_count[j] = (value % 32'd40) + 32'd1;
            take_random(1, value);
            job_endian[j] = value[0];
        end
        // Reset and idle checks first then each job
        watchdog_cycles = 50;
        for (int j = 0; j < job_total; j++) begin
            watchdog_cycles += 60 * int'(job_count[j]) + 200;
        end
    endtask

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------
    task automatic check_idle_after_reset();
        // Long enough for the outputs to reflect the setup state
        repeat (8) begin
            @(posedge ap_clk);
            assert (ap_idle === 1'b1) else
                stop_with_error($sformatf("mismatch ap_idle: got %h expected 1", ap_idle));
            assert (ap_ready === 1'b0) else
                stop_with_error($sformatf("mismatch ap_ready: got %h expected 0", ap_ready));
            assert (ap_done === 1'b0) else
                stop_with_error($sformatf("mismatch ap_done: got %h expected 0", ap_done));
        end
    endtask

    task automatic run_job(input int index);
        logic [63:0] expected;
        int          cycles;
        expected = model_sum(job_base[index], job_count[index], job_endian[index]);
        @(posedge ap_clk);
        ap_start     <= 1'b1;
        base_vertex  <= job_base[index];
        vertex_count <= job_count[index];
        flags        <= {31'd0, job_endian[index]};
        // Start held until the kernel reports ready
        cycles = 0;
        do begin
            @(posedge ap_clk);
            cycles++;
            assert (cycles < wait_limit) else
                stop_with_error($sformatf("job %0d was never accepted, ap_ready stayed low", index));
        end while (ap_ready !== 1'b1);
        ap_start <= 1'b0;
        // Previous done gone by the time ready shows
        assert (ap_done === 1'b0) else
            stop_with_error($sformatf("mismatch ap_done at accept of job %0d: got %h expected 0",
                                      index, ap_done));
        // Never idle while the job runs
        cycles = 0;
        while (ap_done !== 1'b1) begin
            assert (ap_idle === 1'b0) else
                stop_with_error($sformatf("mismatch ap_idle in job %0d: got %h expected 0",
                                          index, ap_idle));
            @(posedge ap_clk);
            cycles++;
            assert (cycles < wait_limit) else
                stop_with_error($sformatf("job %0d never finished, ap_done stayed low", index));
        end
        assert (result === expected) else
            stop_with_error($sformatf("mismatch result in job %0d: got %h expected %h",
                                      index, result, expected));
    endtask

    // Whole-run time limit from the job table
    initial begin
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge ap_clk);
        stop_with_error("watchdog expired before all jobs were finished");
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        areset_control <= 1'b1;
        ap_start       <= 1'b0;
        base_vertex    <= '0;
        vertex_count   <= '0;
        flags          <= '0;
        lfsr_state = 32'h3d2f;
        plan_jobs();
        repeat (8) @(posedge ap_clk);
        areset_control <= 1'b0;
        check_idle_after_reset();
        for (int j = 0; j < job_total; j++) begin
            run_job(j);
        end
        $display("TB PASSED");
        $finish;
    end

endmodule : graph_kernel_tb

`default_nettype wire

// File: compile.f
design/pkg_kernel.sv
design/credit_link_if.sv
design/kernel_control.sv
design/vertex_issue.sv
design/vertex_transform.sv
design/result_accumulate.sv
design/graph_kernel_top.sv
bench/graph_kernel_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the graph kernel testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module graph_kernel_tb \
    -f compile.f \
    -o sim_graph_kernel

./obj_dir/sim_graph_kernel
